/* verilog/gc_pkg.sv */
//////////////////////////////////////////////////////////////////////
// Shared widths, privilege and exception-cause types for the global
// control block, the cause and privilege constants, the MRET funct7
// encoding and the controller state enum
//////////////////////////////////////////////////////////////////////

package gc_pkg;

    //////////////////////////////////////////////////////////////////////
    // Widths with a meaning

    // PC, instruction word or trap value
    typedef logic [31:0] xlen_t;

    // Instruction ID handed out by the issue stage
    typedef logic [2:0] id_t;

    // Exception cause code, as in mcause
    typedef logic [4:0] cause_t;

    // Privilege level encoding
    typedef logic [1:0] priv_t;

    //////////////////////////////////////////////////////////////////////
    // Exception cause codes

    // Fetch target not word aligned, raised by the branch unit
    localparam cause_t CAUSE_INST_MISALIGNED = 5'd0;
    localparam cause_t CAUSE_ILLEGAL_INST = 5'd2;
    localparam cause_t CAUSE_BREAKPOINT = 5'd3;
    // ECALL code depends on the privilege it was issued from
    localparam cause_t CAUSE_ECALL_U = 5'd8;
    localparam cause_t CAUSE_ECALL_M = 5'd11;

    //////////////////////////////////////////////////////////////////////
    // Privilege levels

    // Machine and user only
    localparam priv_t PRIV_USER = 2'd0;
    localparam priv_t PRIV_MACHINE = 2'd3;

    // funct7 field of MRET, instruction bits 31:25
    localparam logic [6:0] MRET_FUNCT7 = 7'b0011000;

    //////////////////////////////////////////////////////////////////////
    // Controller states

    typedef enum logic [2:0] {
        // Held for one cycle after rst
        RST_STATE,
        // Clear counter started here
        PRE_CLEAR_STATE,
        // ID memories being cleared
        INIT_CLEAR_STATE,
        // Normal issue
        IDLE_STATE,
        // Waiting for the load/store unit to go idle
        DRAIN_STATE
    } gc_state_t;

endpackage

/* verilog/gc_clear_counter.sv */
//////////////////////////////////////////////////////////////////////
// One-hot shift counter, done a fixed number of cycles after start
//////////////////////////////////////////////////////////////////////

module gc_clear_counter #(
    parameter int DEPTH = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic start,
    output logic done
);

    // One bit per cycle of delay
    logic [DEPTH-1:0] shift;

    //////////////////////////////////////////////////////////////////////
    // Shift register

    always_ff @(posedge clk) begin
        if (rst) begin
            shift <= '0;
        end else begin
            // Start pulse enters at the bottom, moves up one per cycle
            shift <= (shift << 1) | DEPTH'(start);
        end
    end

    // Top bit set in the DEPTH-th cycle after start
    assign done = shift[DEPTH-1];

endmodule

/* verilog/gc_exception_select.sv */
//////////////////////////////////////////////////////////////////////
// Priority selection of the exception source with its cause code,
// trap value and ID
//////////////////////////////////////////////////////////////////////

module gc_exception_select
    import gc_pkg::*;
(
    // Issue stage
    input  logic   issue_new_request,
    input  logic   is_ecall,
    input  logic   is_ebreak,
    input  logic   illegal_instruction,
    input  xlen_t  instruction,
    input  id_t    issue_id,
    // Branch unit
    input  logic   br_exception_valid,
    input  cause_t br_exception_code,
    input  xlen_t  br_exception_tval,
    input  id_t    br_exception_id,
    // Load/store unit
    input  logic   ls_exception_valid,
    input  cause_t ls_exception_code,
    input  xlen_t  ls_exception_tval,
    input  id_t    ls_exception_id,
    // Trap state
    input  priv_t  current_privilege,
    // Selected exception
    output logic   exception_valid,
    output cause_t exception_cause,
    output xlen_t  exception_tval,
    output id_t    exception_next_id
);

    cause_t ecall_code;
    logic   issue_illegal;
    logic   issue_ecall_break;

    // Issue-stage sources only count with a new request
    assign issue_illegal = issue_new_request & illegal_instruction;
    assign issue_ecall_break = issue_new_request & (is_ecall | is_ebreak);

    // ECALL code by the privilege it came from
    assign ecall_code = (current_privilege == PRIV_USER) ? CAUSE_ECALL_U : CAUSE_ECALL_M;

    assign exception_valid = br_exception_valid | issue_illegal | ls_exception_valid
                           | issue_ecall_break;

    //////////////////////////////////////////////////////////////////////
    // Cause and value, branch first, EBREAK last

    always_comb begin
        if (br_exception_valid) begin
            exception_cause = br_exception_code;
            exception_tval = br_exception_tval;
        end else if (issue_illegal) begin
            // Faulting instruction word as tval
            exception_cause = CAUSE_ILLEGAL_INST;
            exception_tval = instruction;
        end else if (ls_exception_valid) begin
            exception_cause = ls_exception_code;
            exception_tval = ls_exception_tval;
        end else if (is_ecall) begin
            exception_cause = ecall_code;
            exception_tval = '0;
        end else begin
            exception_cause = CAUSE_BREAKPOINT;
            exception_tval = '0;
        end
    end

    // ID from the execute units, else the issuing instruction
    assign exception_next_id = br_exception_valid ? br_exception_id :
                               ls_exception_valid ? ls_exception_id : issue_id;

endmodule

/* verilog/gc_trap_state.sv */
//////////////////////////////////////////////////////////////////////
// Machine trap registers: cause, value, exception PC, previous and
// current privilege, updated on trap entry and on MRET
//////////////////////////////////////////////////////////////////////

module gc_trap_state
    import gc_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    // Trap entry
    input  logic   exception_valid,
    input  cause_t exception_cause,
    input  xlen_t  exception_tval,
    input  xlen_t  issue_pc,
    // Trap return pulse
    input  logic   mret,
    // Trap state
    output cause_t trap_cause,
    output xlen_t  trap_value,
    output xlen_t  trap_epc,
    output priv_t  current_privilege
);

    // Privilege held in the register
    priv_t privilege_q;
    // Privilege before the last trap, as in mstatus.MPP
    priv_t previous_privilege;

    //////////////////////////////////////////////////////////////////////
    // Trap registers

    always_ff @(posedge clk) begin
        if (rst) begin
            trap_cause <= '0;
            trap_value <= '0;
            trap_epc <= '0;
        end else if (exception_valid) begin
            trap_cause <= exception_cause;
            trap_value <= exception_tval;
            // Faulting or trapping instruction address
            trap_epc <= issue_pc;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Privilege

    always_ff @(posedge clk) begin
        if (rst) begin
            privilege_q <= PRIV_MACHINE;
            // First MRET out of reset lands in user mode
            previous_privilege <= PRIV_USER;
        end else if (exception_valid) begin
            // Trap entry, always into machine mode
            previous_privilege <= current_privilege;
            privilege_q <= PRIV_MACHINE;
        end else if (mret) begin
            privilege_q <= previous_privilege;
            previous_privilege <= PRIV_USER;
        end
    end

    // Restored level visible in the same cycle as the mret pulse
    assign current_privilege = mret ? previous_privilege : privilege_q;

endmodule

/* verilog/gc_unit.sv */
//////////////////////////////////////////////////////////////////////
// Global control FSM: reset clear, drain after system ops and traps,
// registered hold, flush and clear outputs, fetch PC selection
//////////////////////////////////////////////////////////////////////

module gc_unit
    import gc_pkg::*;
#(
    parameter int    INIT_CLEAR_DEPTH = 16,
    parameter xlen_t TRAP_VECTOR = 32'h0000_0100
) (
    input  logic  clk,
    input  logic  rst,
    // Issue stage
    input  logic  issue_new_request,
    input  logic  is_ret,
    input  logic  is_fence_i,
    input  xlen_t instruction,
    input  xlen_t issue_pc,
    // Exception select
    input  logic  exception_valid,
    input  id_t   exception_next_id,
    // Trap state
    input  xlen_t saved_epc,
    // Execute stage
    input  logic  branch_flush,
    input  logic  ls_is_idle,
    // Trap status
    output id_t   exception_id,
    output logic  mret,
    // Pipeline controls
    output logic  gc_init_clear,
    output logic  gc_fetch_hold,
    output logic  gc_issue_hold,
    output logic  gc_fetch_flush,
    output logic  gc_fetch_pc_override,
    output xlen_t gc_fetch_pc,
    output logic  gc_suppress_writeback
);

    gc_state_t state;
    gc_state_t next_state;

    logic init_clear_done;
    logic mret_request;
    logic fence_i_request;
    logic system_op;
    // Second override cycle of a FENCE.I
    logic second_cycle_flush;

    // MRET by is_ret plus the funct7 field
    assign mret_request = issue_new_request & is_ret & (instruction[31:25] == MRET_FUNCT7);
    assign fence_i_request = issue_new_request & is_fence_i;
    assign system_op = mret_request | fence_i_request;

    //////////////////////////////////////////////////////////////////////
    // State machine

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= RST_STATE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RST_STATE: next_state = PRE_CLEAR_STATE;
            PRE_CLEAR_STATE: next_state = INIT_CLEAR_STATE;
            INIT_CLEAR_STATE: if (init_clear_done) next_state = IDLE_STATE;
            // Any trap or system op waits for the load/store unit
            IDLE_STATE: if (exception_valid | system_op) next_state = DRAIN_STATE;
            DRAIN_STATE: if (ls_is_idle) next_state = IDLE_STATE;
            default: next_state = RST_STATE;
        endcase
    end

    // Clear window length, started from the pre-clear cycle
    gc_clear_counter #(
        .DEPTH(INIT_CLEAR_DEPTH)
    ) init_clear_counter (
        .clk  (clk),
        .rst  (rst),
        .start(state == PRE_CLEAR_STATE),
        .done (init_clear_done)
    );

    //////////////////////////////////////////////////////////////////////
    // Registered controls

    always_ff @(posedge clk) begin
        if (rst) begin
            gc_init_clear <= 1'b0;
            gc_fetch_hold <= 1'b0;
            gc_issue_hold <= 1'b0;
            gc_suppress_writeback <= 1'b0;
            mret <= 1'b0;
            second_cycle_flush <= 1'b0;
            gc_fetch_pc_override <= 1'b0;
        end else begin
            gc_init_clear <= (next_state == INIT_CLEAR_STATE);
            gc_fetch_hold <= next_state inside {PRE_CLEAR_STATE, INIT_CLEAR_STATE};
            // One-cycle hold after every request, longer while draining
            gc_issue_hold <= issue_new_request
                           | (next_state inside {PRE_CLEAR_STATE, INIT_CLEAR_STATE, DRAIN_STATE});
            gc_suppress_writeback <= next_state inside {PRE_CLEAR_STATE, INIT_CLEAR_STATE};
            mret <= mret_request;
            second_cycle_flush <= fence_i_request;
            gc_fetch_pc_override <= exception_valid | system_op | second_cycle_flush;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Fetch redirect

    always_ff @(posedge clk) begin
        if (rst) begin
            gc_fetch_pc <= '0;
        end else if (exception_valid) begin
            gc_fetch_pc <= TRAP_VECTOR;
        end else if (mret_request) begin
            gc_fetch_pc <= saved_epc;
        end else if (fence_i_request) begin
            // Refetch from the instruction after the FENCE.I
            gc_fetch_pc <= issue_pc + xlen_t'(4);
        end
    end

    // ID of the trapping or system instruction
    always_ff @(posedge clk) begin
        if (exception_valid | system_op) begin
            exception_id <= exception_next_id;
        end
    end

    assign gc_fetch_flush = branch_flush | gc_fetch_pc_override;

endmodule

/* verilog/gc_subsystem.sv */
//////////////////////////////////////////////////////////////////////
// Top level of the global control block: exception selection, trap
// state and control FSM
//////////////////////////////////////////////////////////////////////

module gc_subsystem
    import gc_pkg::*;
#(
    parameter int    INIT_CLEAR_DEPTH = 16,
    parameter xlen_t TRAP_VECTOR = 32'h0000_0100
) (
    input  logic   clk,
    input  logic   rst,
    // Issue stage
    input  logic   issue_new_request,
    input  id_t    issue_id,
    input  logic   is_ecall,
    input  logic   is_ebreak,
    input  logic   is_ret,
    input  logic   is_fence_i,
    input  xlen_t  instruction,
    input  xlen_t  issue_pc,
    input  logic   illegal_instruction,
    // Branch unit
    input  logic   br_exception_valid,
    input  cause_t br_exception_code,
    input  xlen_t  br_exception_tval,
    input  id_t    br_exception_id,
    input  logic   branch_flush,
    // Load/store unit
    input  logic   ls_exception_valid,
    input  cause_t ls_exception_code,
    input  xlen_t  ls_exception_tval,
    input  id_t    ls_exception_id,
    input  logic   ls_is_idle,
    // Pipeline controls
    output logic   gc_init_clear,
    output logic   gc_fetch_hold,
    output logic   gc_issue_hold,
    output logic   gc_fetch_flush,
    output logic   gc_fetch_pc_override,
    output xlen_t  gc_fetch_pc,
    output logic   gc_suppress_writeback,
    // Trap status
    output id_t    exception_id,
    output logic   mret,
    output cause_t trap_cause,
    output xlen_t  trap_value,
    output xlen_t  trap_epc,
    output priv_t  current_privilege
);

    logic   exception_valid;
    cause_t exception_cause;
    xlen_t  exception_tval;
    id_t    exception_next_id;

    //////////////////////////////////////////////////////////////////////
    // Exception source priority

    gc_exception_select exception_select (
        .issue_new_request  (issue_new_request),
        .is_ecall           (is_ecall),
        .is_ebreak          (is_ebreak),
        .illegal_instruction(illegal_instruction),
        .instruction        (instruction),
        .issue_id           (issue_id),
        .br_exception_valid (br_exception_valid),
        .br_exception_code  (br_exception_code),
        .br_exception_tval  (br_exception_tval),
        .br_exception_id    (br_exception_id),
        .ls_exception_valid (ls_exception_valid),
        .ls_exception_code  (ls_exception_code),
        .ls_exception_tval  (ls_exception_tval),
        .ls_exception_id    (ls_exception_id),
        .current_privilege  (current_privilege),
        .exception_valid    (exception_valid),
        .exception_cause    (exception_cause),
        .exception_tval     (exception_tval),
        .exception_next_id  (exception_next_id)
    );

    // Machine trap registers
    gc_trap_state trap_state (
        .clk              (clk),
        .rst              (rst),
        .exception_valid  (exception_valid),
        .exception_cause  (exception_cause),
        .exception_tval   (exception_tval),
        .issue_pc         (issue_pc),
        .mret             (mret),
        .trap_cause       (trap_cause),
        .trap_value       (trap_value),
        .trap_epc         (trap_epc),
        .current_privilege(current_privilege)
    );

    //////////////////////////////////////////////////////////////////////
    // Control FSM and fetch redirect

    gc_unit #(
        .INIT_CLEAR_DEPTH(INIT_CLEAR_DEPTH),
        .TRAP_VECTOR     (TRAP_VECTOR)
    ) unit (
        .clk                  (clk),
        .rst                  (rst),
        .issue_new_request    (issue_new_request),
        .is_ret               (is_ret),
        .is_fence_i           (is_fence_i),
        .instruction          (instruction),
        .issue_pc             (issue_pc),
        .exception_valid      (exception_valid),
        .exception_next_id    (exception_next_id),
        .saved_epc            (trap_epc),
        .branch_flush         (branch_flush),
        .ls_is_idle           (ls_is_idle),
        .exception_id         (exception_id),
        .mret                 (mret),
        .gc_init_clear        (gc_init_clear),
        .gc_fetch_hold        (gc_fetch_hold),
        .gc_issue_hold        (gc_issue_hold),
        .gc_fetch_flush       (gc_fetch_flush),
        .gc_fetch_pc_override (gc_fetch_pc_override),
        .gc_fetch_pc          (gc_fetch_pc),
        .gc_suppress_writeback(gc_suppress_writeback)
    );

endmodule

/* test/gc_subsystem_assertions.sv */
//////////////////////////////////////////////////////////////////////
// Concurrent checks on the global control outputs, bound into the
// top level of the global control block
//////////////////////////////////////////////////////////////////////

module gc_subsystem_assertions
    import gc_pkg::*;
(
    input logic  clk,
    input logic  rst,
    input logic  issue_new_request,
    input logic  branch_flush,
    input logic  gc_init_clear,
    input logic  gc_fetch_hold,
    input logic  gc_issue_hold,
    input logic  gc_fetch_flush,
    input logic  gc_fetch_pc_override,
    input logic  mret,
    input priv_t current_privilege
);

    timeunit 1ns;
    timeprecision 1ps;

    // Count of failed checks, polled by the testbench
    int failures = 0;

    //////////////////////////////////////////////////////////////////////
    // Reset and clear window

    // Controls quiet and machine mode right after a reset edge
    a_reset_quiet: assert property (@(posedge clk)
        rst |=> !(gc_init_clear | gc_fetch_hold | gc_issue_hold | gc_fetch_pc_override | mret)
                && (current_privilege == PRIV_MACHINE))
    else begin
        $error("Control output active or privilege not machine after reset");
        failures++;
    end

    // No redirect while the ID memories are cleared
    a_no_override_in_clear: assert property (@(posedge clk) disable iff (rst)
        gc_init_clear |-> !gc_fetch_pc_override)
    else begin
        $error("Fetch PC override during init clear");
        failures++;
    end

    //////////////////////////////////////////////////////////////////////
    // Per-cycle rules

    // Trap return is a single-cycle pulse
    a_mret_pulse: assert property (@(posedge clk) disable iff (rst)
        mret |=> !mret)
    else begin
        $error("mret high for more than one cycle");
        failures++;
    end

    // Flush is the branch flush ORed with the redirect
    a_flush_follows_branch: assert property (@(posedge clk) disable iff (rst)
        gc_fetch_flush == (branch_flush | gc_fetch_pc_override))
    else begin
        $error("Fetch flush does not follow branch flush and override");
        failures++;
    end

    // Issue held in the cycle after each request
    a_hold_after_request: assert property (@(posedge clk) disable iff (rst)
        issue_new_request |=> gc_issue_hold)
    else begin
        $error("Issue hold missing after a new request");
        failures++;
    end

endmodule

bind gc_subsystem gc_subsystem_assertions gc_checks (
    .clk                 (clk),
    .rst                 (rst),
    .issue_new_request   (issue_new_request),
    .branch_flush        (branch_flush),
    .gc_init_clear       (gc_init_clear),
    .gc_fetch_hold       (gc_fetch_hold),
    .gc_issue_hold       (gc_issue_hold),
    .gc_fetch_flush      (gc_fetch_flush),
    .gc_fetch_pc_override(gc_fetch_pc_override),
    .mret                (mret),
    .current_privilege   (current_privilege)
);

/* test/gc_subsystem_tb.sv */
//////////////////////////////////////////////////////////////////////
// Testbench for the global control block: reset clear, MRET and
// ECALL, exception priority, FENCE.I, drain and branch flush
//////////////////////////////////////////////////////////////////////

module gc_subsystem_tb
    import gc_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int    INIT_CLEAR_DEPTH = 16;
    localparam xlen_t TRAP_VECTOR = 32'h0000_0100;
    // Bound on every wait loop, in cycles
    localparam int    WAIT_LIMIT = 64;

    logic   clk;
    logic   rst;
    logic   issue_new_request;
    id_t    issue_id;
    logic   is_ecall;
    logic   is_ebreak;
    logic   is_ret;
    logic   is_fence_i;
    xlen_t  instruction;
    xlen_t  issue_pc;
    logic   illegal_instruction;
    logic   br_exception_valid;
    cause_t br_exception_code;
    xlen_t  br_exception_tval;
    id_t    br_exception_id;
    logic   branch_flush;
    logic   ls_exception_valid;
    cause_t ls_exception_code;
    xlen_t  ls_exception_tval;
    id_t    ls_exception_id;
    logic   ls_is_idle;
    logic   gc_init_clear;
    logic   gc_fetch_hold;
    logic   gc_issue_hold;
    logic   gc_fetch_flush;
    logic   gc_fetch_pc_override;
    xlen_t  gc_fetch_pc;
    logic   gc_suppress_writeback;
    id_t    exception_id;
    logic   mret;
    cause_t trap_cause;
    xlen_t  trap_value;
    xlen_t  trap_epc;
    priv_t  current_privilege;

    // Reference trap state
    cause_t exp_cause;
    xlen_t  exp_value;
    xlen_t  exp_epc;
    priv_t  exp_priv;
    priv_t  exp_prev_priv;
    integer seed = 32'h534;

    gc_subsystem #(
        .INIT_CLEAR_DEPTH(INIT_CLEAR_DEPTH),
        .TRAP_VECTOR     (TRAP_VECTOR)
    ) UUT (.*);

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Reporting and checks

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTBENCH FAILED");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic check_value(input xlen_t actual, input xlen_t expected, input string what);
        assert (actual === expected) else begin
            abort_run($sformatf("CHECK FAILED at time %0t: %s is %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        check_value(xlen_t'(actual), xlen_t'(expected), what);
    endtask

    // Bound checks are polled once per cycle
    always @(negedge clk) begin
        if (UUT.gc_checks.failures != 0) begin
            abort_run($sformatf("A bound assertion failed before time %0t", $time));
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    task automatic drive_idle();
        issue_new_request = 1'b0;
        is_ecall = 1'b0;
        is_ebreak = 1'b0;
        is_ret = 1'b0;
        is_fence_i = 1'b0;
        illegal_instruction = 1'b0;
        br_exception_valid = 1'b0;
        ls_exception_valid = 1'b0;
        branch_flush = 1'b0;
        ls_is_idle = 1'b1;
    endtask

    // One-cycle pulse, returns in the response cycle
    task automatic issue_request();
        issue_new_request = 1'b1;
        @(negedge clk);
        drive_idle();
    endtask

    task automatic wait_issue_ready();
        int cycles;
        cycles = 0;
        while (gc_issue_hold && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (gc_issue_hold) begin
            abort_run($sformatf("Timeout at time %0t: issue hold never released", $time));
        end
    endtask

    // Trap entry response one cycle after the request
    task automatic expect_trap(input cause_t cause, input xlen_t value, input xlen_t epc);
        exp_cause = cause;
        exp_value = value;
        exp_epc = epc;
        exp_prev_priv = exp_priv;
        exp_priv = PRIV_MACHINE;
        check_bit(gc_fetch_pc_override, 1'b1, "trap override");
        check_value(gc_fetch_pc, TRAP_VECTOR, "trap fetch PC");
        check_value(xlen_t'(trap_cause), xlen_t'(exp_cause), "trap cause");
        check_value(trap_value, exp_value, "trap value");
        check_value(trap_epc, exp_epc, "trap EPC");
        check_value(xlen_t'(current_privilege), xlen_t'(exp_priv), "privilege after trap");
    endtask

    task automatic run_ecall(input xlen_t pc);
        cause_t want_cause;
        // ECALL code by the privilege it is issued from
        want_cause = (exp_priv == PRIV_USER) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
        wait_issue_ready();
        instruction = 32'h0000_0073;
        issue_pc = pc;
        is_ecall = 1'b1;
        issue_request();
        expect_trap(want_cause, '0, pc);
    endtask

    // MRET, back to the saved EPC with the saved privilege
    task automatic return_from_trap(input xlen_t pc);
        wait_issue_ready();
        instruction = 32'h3020_0073;
        issue_pc = pc;
        is_ret = 1'b1;
        issue_request();
        exp_priv = exp_prev_priv;
        exp_prev_priv = PRIV_USER;
        check_bit(mret, 1'b1, "mret pulse");
        check_bit(gc_fetch_pc_override, 1'b1, "mret override");
        check_value(gc_fetch_pc, exp_epc, "mret fetch PC");
        check_value(xlen_t'(current_privilege), xlen_t'(exp_priv), "privilege after mret");
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int     cycles;
        int     clear_cycles;
        int     drain_cycles;
        cause_t want_cause;
        xlen_t  want_value;
        id_t    want_id;
        xlen_t  fence_pc;

        drive_idle();
        rst = 1'b1;
        issue_id = '0;
        instruction = '0;
        issue_pc = '0;
        br_exception_code = CAUSE_INST_MISALIGNED;
        br_exception_tval = '0;
        br_exception_id = '0;
        ls_exception_code = '0;
        ls_exception_tval = '0;
        ls_exception_id = '0;
        exp_cause = '0;
        exp_value = '0;
        exp_epc = '0;
        exp_priv = PRIV_MACHINE;
        exp_prev_priv = PRIV_USER;

        // Reset, all controls quiet
        repeat (4) begin
            @(negedge clk);
            check_bit(gc_init_clear | gc_fetch_hold | gc_issue_hold, 1'b0, "controls in reset");
            check_bit(gc_fetch_pc_override | mret, 1'b0, "redirect in reset");
        end
        rst = 1'b0;
        @(negedge clk);
        check_bit(gc_fetch_hold, 1'b1, "pre-clear fetch hold");

        // Clear window length
        cycles = 0;
        while (!gc_init_clear && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (!gc_init_clear) begin
            abort_run($sformatf("Timeout at time %0t: init clear never started", $time));
        end
        clear_cycles = 0;
        while (gc_init_clear && clear_cycles < WAIT_LIMIT) begin
            check_bit(gc_fetch_hold & gc_issue_hold, 1'b1, "holds during clear");
            check_bit(gc_suppress_writeback, 1'b1, "writeback suppress during clear");
            clear_cycles++;
            @(negedge clk);
        end
        check_value(xlen_t'(clear_cycles), xlen_t'(INIT_CLEAR_DEPTH), "init clear length");
        check_bit(gc_fetch_hold | gc_issue_hold | gc_suppress_writeback, 1'b0,
                  "holds after clear");

        // MRET from machine mode into user mode
        return_from_trap(32'h0000_0200);

        // User ECALL, then machine ECALL
        run_ecall(32'h0000_0400);
        run_ecall(32'h0000_0480);

        // MRET back to the machine ECALL address
        return_from_trap(32'h0000_0500);

        // Priority among branch, illegal, load/store, EBREAK
        for (int combo = 7; combo >= 0; combo--) begin
            wait_issue_ready();
            br_exception_valid = combo[2];
            illegal_instruction = combo[1];
            ls_exception_valid = combo[0];
            br_exception_code = cause_t'($random(seed));
            br_exception_tval = $random(seed);
            br_exception_id = id_t'($random(seed));
            ls_exception_code = cause_t'($random(seed));
            ls_exception_tval = $random(seed);
            ls_exception_id = id_t'($random(seed));
            instruction = $random(seed);
            issue_id = id_t'($random(seed));
            issue_pc = xlen_t'($random(seed)) & 32'hffff_fffc;
            is_ebreak = 1'b1;
            if (combo[2]) begin
                want_cause = br_exception_code;
                want_value = br_exception_tval;
            end else if (combo[1]) begin
                want_cause = CAUSE_ILLEGAL_INST;
                want_value = instruction;
            end else if (combo[0]) begin
                want_cause = ls_exception_code;
                want_value = ls_exception_tval;
            end else begin
                want_cause = CAUSE_BREAKPOINT;
                want_value = '0;
            end
            want_id = combo[2] ? br_exception_id : (combo[0] ? ls_exception_id : issue_id);
            issue_request();
            expect_trap(want_cause, want_value, issue_pc);
            check_value(xlen_t'(exception_id), xlen_t'(want_id), "exception ID");
        end

        // FENCE.I, two override cycles to the next instruction
        wait_issue_ready();
        fence_pc = 32'h0000_0800;
        instruction = 32'h0000_100f;
        issue_pc = fence_pc;
        is_fence_i = 1'b1;
        issue_request();
        check_bit(gc_fetch_pc_override, 1'b1, "fence.i first override");
        check_bit(gc_fetch_flush, 1'b1, "fence.i flush");
        check_value(gc_fetch_pc, fence_pc + 32'd4, "fence.i fetch PC");
        @(negedge clk);
        check_bit(gc_fetch_pc_override, 1'b1, "fence.i second override");
        check_value(gc_fetch_pc, fence_pc + 32'd4, "fence.i fetch PC, second cycle");
        @(negedge clk);
        check_bit(gc_fetch_pc_override, 1'b0, "override after fence.i");

        // Drain with a busy load/store unit
        drain_cycles = 1 + int'($unsigned($random(seed)) % 8);
        run_ecall(32'h0000_0a00);
        ls_is_idle = 1'b0;
        repeat (drain_cycles) begin
            check_bit(gc_issue_hold, 1'b1, "issue hold while draining");
            @(negedge clk);
        end
        check_bit(gc_issue_hold, 1'b1, "issue hold before idle");
        ls_is_idle = 1'b1;
        @(negedge clk);
        check_bit(gc_issue_hold, 1'b0, "issue hold after idle");

        // Branch flush alone, mid-cycle sample
        wait_issue_ready();
        branch_flush = 1'b1;
        #2;
        check_bit(gc_fetch_flush, 1'b1, "flush from branch");
        check_bit(gc_fetch_pc_override, 1'b0, "override on branch flush");
        @(negedge clk);
        branch_flush = 1'b0;
        check_bit(gc_fetch_pc_override, 1'b0, "override after branch flush");
        check_value(xlen_t'(trap_cause), xlen_t'(exp_cause), "cause after branch flush");
        check_value(trap_value, exp_value, "value after branch flush");
        check_value(trap_epc, exp_epc, "EPC after branch flush");

        @(negedge clk);
        if (UUT.gc_checks.failures == 0) begin
            $display("TESTBENCH PASSED");
            $finish;
        end else begin
            abort_run("Bound assertion failures at the end of the run");
        end
    end

endmodule

/* gc_subsystem.f */
verilog/gc_pkg.sv
verilog/gc_clear_counter.sv
verilog/gc_exception_select.sv
verilog/gc_trap_state.sv
verilog/gc_unit.sv
verilog/gc_subsystem.sv
test/gc_subsystem_assertions.sv
test/gc_subsystem_tb.sv

/* Makefile */
# Verilator build, run and lint for the global control block

VERILATOR  = verilator
TOP        = gc_subsystem_tb
RTL_TOP    = gc_subsystem
FILELIST   = gc_subsystem.f
BUILD_DIR  = obj_dir
COMMON     = --timing --assert --timescale 1ns/1ps
SIM_FLAGS  = --binary -j 0 $(COMMON)
LINT_FLAGS = --lint-only $(COMMON)
RUN_FLAGS  = +verilator+error+limit+100

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
